// File: design/oq_regs_cfg.svh
/*
 * Build-time configuration of the output-queue register block.
 * Queue count, field widths and reset values of the per-queue registers.
 * Included by the package and by every module that sizes or resets state.
 */

`ifndef OQ_REGS_CFG_SVH
`define OQ_REGS_CFG_SVH

// ---------------------------------------------------------------------------
// Queue geometry
// ---------------------------------------------------------------------------

// Number of output queues
`define OQ_NUM_QUEUES 4

// Capacity of one queue in words
`define OQ_QUEUE_WORDS 2048

// ---------------------------------------------------------------------------
// Field widths
// ---------------------------------------------------------------------------

`define OQ_PKT_CNT_WIDTH 10
`define OQ_WORD_CNT_WIDTH 13

// Stored, removed and dropped statistics
`define OQ_STAT_WIDTH 16

// Host data bus and register index inside one queue
`define OQ_REG_DATA_WIDTH 32
`define OQ_REG_IDX_WIDTH 3

// ---------------------------------------------------------------------------
// Reset values
// ---------------------------------------------------------------------------

`define OQ_MAX_PKTS_RESET 64
`define OQ_FULL_THRESH_RESET 256

`endif

// File: design/oq_regs_pkg.sv
/*
 * Types shared by the output-queue register block.
 * Queue numbers and masks, counter types, host data and the register map.
 * Modules pull these in with a wildcard import in their header.
 */

`include "oq_regs_cfg.svh"

package oq_regs_pkg;

   typedef logic [$clog2(`OQ_NUM_QUEUES)-1:0] oq_idx_t;
   typedef logic [`OQ_NUM_QUEUES-1:0]         oq_mask_t;

   typedef logic [`OQ_PKT_CNT_WIDTH-1:0]  pkt_cnt_t;
   typedef logic [`OQ_WORD_CNT_WIDTH-1:0] word_cnt_t;
   typedef logic [`OQ_STAT_WIDTH-1:0]     stat_cnt_t;
   typedef logic [`OQ_REG_DATA_WIDTH-1:0] reg_data_t;

   // Register index inside one queue, 3 and up are read only
   typedef enum logic [`OQ_REG_IDX_WIDTH-1:0] {
      REG_CTRL             = 3'd0,
      REG_MAX_PKTS         = 3'd1,
      REG_FULL_THRESH      = 3'd2,
      REG_NUM_PKTS_IN_Q    = 3'd3,
      REG_NUM_WORDS_LEFT   = 3'd4,
      REG_NUM_PKTS_STORED  = 3'd5,
      REG_NUM_PKTS_REMOVED = 3'd6,
      REG_NUM_PKTS_DROPPED = 3'd7
   } oq_reg_e;

   // Host address, queue number on top of the register index
   typedef struct packed {
      oq_idx_t oq;
      oq_reg_e idx;
   } reg_addr_t;

   // Control register bits
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_INIT_BIT   = 1;

endpackage

// File: design/oq_event_decode.sv
/*
 * Accepts store and remove events and turns them into update strobes.
 * Remove wins when both are valid. A store to a full or disabled queue
 * is turned into a drop. Strobes are registered one cycle after accept.
 */

`timescale 1ns/10ps

module oq_event_decode
   import oq_regs_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,

   input  logic      store_valid,
   input  oq_idx_t   store_oq,
   input  word_cnt_t store_words,
   output logic      store_ready,

   input  logic      remove_valid,
   input  oq_idx_t   remove_oq,
   input  word_cnt_t remove_words,
   output logic      remove_ready,

   input  oq_mask_t  full,
   input  oq_mask_t  enable,

   output oq_mask_t  upd_store,
   output oq_mask_t  upd_remove,
   output oq_mask_t  upd_drop,
   output word_cnt_t upd_words
);

   logic     ev_ready;
   logic     remove_acc;
   logic     store_acc;
   logic     store_ok;
   oq_mask_t remove_sel;
   oq_mask_t store_sel;

   // Ready rises in the first cycle out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ev_ready <= 1'b0;
      end else begin
         ev_ready <= 1'b1;
      end
   end

   // Remove has priority so store backs off whenever remove is valid
   assign remove_ready = ev_ready;
   assign store_ready  = ev_ready & ~remove_valid;

   assign remove_acc = remove_valid & remove_ready;
   assign store_acc  = store_valid & store_ready;

   assign remove_sel = oq_mask_t'(1) << remove_oq;
   assign store_sel  = oq_mask_t'(1) << store_oq;

   // Flags as they stand now, events still in flight are not seen
   assign store_ok = enable[store_oq] & ~full[store_oq];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         upd_store  <= '0;
         upd_remove <= '0;
         upd_drop   <= '0;
      end else begin
         upd_remove <= remove_acc ? remove_sel : '0;
         upd_store  <= (store_acc && store_ok) ? store_sel : '0;
         upd_drop   <= (store_acc && !store_ok) ? store_sel : '0;
      end
   end

   // Word length travels with the accepted event
   always_ff @(posedge clk) begin
      if (remove_acc) begin
         upd_words <= remove_words;
      end else if (store_acc) begin
         upd_words <= store_words;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({upd_store, upd_remove, upd_drop}))
      else $error("more than one queue update strobe in a cycle");

endmodule

// File: design/oq_queue_state.sv
/*
 * State of one output queue.
 * Packet and word counters, statistics and configuration, updated by the
 * decoder strobes and by host configuration writes. Drives empty and full.
 */

`timescale 1ns/10ps

`include "oq_regs_cfg.svh"

module oq_queue_state
   import oq_regs_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,

   input  logic      upd_store,
   input  logic      upd_remove,
   input  logic      upd_drop,
   input  word_cnt_t upd_words,

   input  logic      cfg_wr,
   input  oq_reg_e   cfg_idx,
   input  reg_data_t cfg_data,

   output pkt_cnt_t  num_pkts_in_q,
   output pkt_cnt_t  max_pkts,
   output word_cnt_t num_words_left,
   output word_cnt_t full_thresh,
   output stat_cnt_t num_stored,
   output stat_cnt_t num_removed,
   output stat_cnt_t num_dropped,
   output logic      empty,
   output logic      full,
   output logic      enable
);

   logic ctrl_wr;
   logic init;

   assign ctrl_wr = cfg_wr && (cfg_idx == REG_CTRL);

   // Initialize bit is a pulse only, it is never stored
   assign init = ctrl_wr && cfg_data[CTRL_INIT_BIT];

   // ------------------------------------------------------------------------
   // Configuration
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable      <= 1'b0;
         max_pkts    <= pkt_cnt_t'(`OQ_MAX_PKTS_RESET);
         full_thresh <= word_cnt_t'(`OQ_FULL_THRESH_RESET);
      end else if (cfg_wr) begin
         case (cfg_idx)
            REG_CTRL:        enable      <= cfg_data[CTRL_ENABLE_BIT];
            REG_MAX_PKTS:    max_pkts    <= pkt_cnt_t'(cfg_data);
            REG_FULL_THRESH: full_thresh <= word_cnt_t'(cfg_data);
            default:         ;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Counters and statistics
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         num_pkts_in_q  <= '0;
         num_words_left <= word_cnt_t'(`OQ_QUEUE_WORDS);
         num_stored     <= '0;
         num_removed    <= '0;
         num_dropped    <= '0;
      end else if (init) begin
         // Back to an empty queue, enable and limits untouched
         num_pkts_in_q  <= '0;
         num_words_left <= word_cnt_t'(`OQ_QUEUE_WORDS);
         num_stored     <= '0;
         num_removed    <= '0;
         num_dropped    <= '0;
      end else begin
         if (upd_store) begin
            num_pkts_in_q  <= num_pkts_in_q + 1'b1;
            num_words_left <= num_words_left - upd_words;
            num_stored     <= num_stored + 1'b1;
         end
         if (upd_remove) begin
            num_pkts_in_q  <= num_pkts_in_q - 1'b1;
            num_words_left <= num_words_left + upd_words;
            num_removed    <= num_removed + 1'b1;
         end
         if (upd_drop) begin
            num_dropped <= num_dropped + 1'b1;
         end
      end
   end

   // Flags
   assign empty = (num_pkts_in_q == '0);
   assign full  = (num_pkts_in_q >= max_pkts) || (num_words_left < full_thresh);

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------

   // The remove engine only takes packets from a queue that holds some
   a_no_remove_empty: assert property (@(posedge clk) disable iff (!arst_n)
      upd_remove |-> !empty)
      else $error("remove from an empty queue");

   // Decoder saw this queue not full at the accepting edge
   a_no_store_full: assert property (@(posedge clk) disable iff (!arst_n)
      upd_store |-> !$past(full))
      else $error("store accepted into a full queue");

endmodule

// File: design/oq_host_regs.sv
/*
 * Host register port of the output-queue block.
 * One request at a time with a single response register. Writes become a
 * one-cycle configuration strobe, reads pick one queue register.
 */

`timescale 1ns/10ps

`include "oq_regs_cfg.svh"

module oq_host_regs
   import oq_regs_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,

   input  logic      req_valid,
   input  logic      req_write,
   input  reg_addr_t req_addr,
   input  reg_data_t req_wdata,
   output logic      req_ready,

   output logic      resp_valid,
   output reg_data_t resp_rdata,
   input  logic      resp_ready,

   output oq_mask_t  cfg_wr,
   output oq_reg_e   cfg_idx,
   output reg_data_t cfg_data,

   input  pkt_cnt_t  num_pkts_in_q  [`OQ_NUM_QUEUES],
   input  pkt_cnt_t  max_pkts       [`OQ_NUM_QUEUES],
   input  word_cnt_t num_words_left [`OQ_NUM_QUEUES],
   input  word_cnt_t full_thresh    [`OQ_NUM_QUEUES],
   input  stat_cnt_t num_stored     [`OQ_NUM_QUEUES],
   input  stat_cnt_t num_removed    [`OQ_NUM_QUEUES],
   input  stat_cnt_t num_dropped    [`OQ_NUM_QUEUES],
   input  oq_mask_t  enable
);

   logic      req_acc;
   reg_data_t rd_val;
   oq_idx_t   q;

   assign q         = req_addr.oq;
   assign req_ready = ~resp_valid;
   assign req_acc   = req_valid & req_ready;

   // ------------------------------------------------------------------------
   // Readback multiplexer
   // ------------------------------------------------------------------------

   always_comb begin
      rd_val = '0;
      case (req_addr.idx)
         REG_CTRL:             rd_val[CTRL_ENABLE_BIT] = enable[q];
         REG_MAX_PKTS:         rd_val = reg_data_t'(max_pkts[q]);
         REG_FULL_THRESH:      rd_val = reg_data_t'(full_thresh[q]);
         REG_NUM_PKTS_IN_Q:    rd_val = reg_data_t'(num_pkts_in_q[q]);
         REG_NUM_WORDS_LEFT:   rd_val = reg_data_t'(num_words_left[q]);
         REG_NUM_PKTS_STORED:  rd_val = reg_data_t'(num_stored[q]);
         REG_NUM_PKTS_REMOVED: rd_val = reg_data_t'(num_removed[q]);
         REG_NUM_PKTS_DROPPED: rd_val = reg_data_t'(num_dropped[q]);
         default:              rd_val = '0;
      endcase
   end

   // ------------------------------------------------------------------------
   // Response register
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_valid <= 1'b0;
      end else if (req_acc) begin
         resp_valid <= 1'b1;
      end else if (resp_ready) begin
         resp_valid <= 1'b0;
      end
   end

   // Writes answer with zero
   always_ff @(posedge clk) begin
      if (req_acc) begin
         resp_rdata <= req_write ? '0 : rd_val;
      end
   end

   // ------------------------------------------------------------------------
   // Configuration write strobe
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg_wr <= '0;
      end else begin
         cfg_wr <= (req_acc && req_write) ? (oq_mask_t'(1) << q) : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (req_acc) begin
         cfg_idx  <= req_addr.idx;
         cfg_data <= req_wdata;
      end
   end

   a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
      else $error("response changed while stalled");

endmodule

// File: design/oq_regs.sv
/*
 * Per-queue state of the shared-memory output-queue block.
 * Store and remove events update the queue counters, the host port reads
 * them back and writes the queue configuration.
 */

`timescale 1ns/10ps

`include "oq_regs_cfg.svh"

module oq_regs
   import oq_regs_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,

   input  logic      store_valid,
   input  oq_idx_t   store_oq,
   input  word_cnt_t store_words,
   output logic      store_ready,

   input  logic      remove_valid,
   input  oq_idx_t   remove_oq,
   input  word_cnt_t remove_words,
   output logic      remove_ready,

   input  logic      req_valid,
   input  logic      req_write,
   input  reg_addr_t req_addr,
   input  reg_data_t req_wdata,
   output logic      req_ready,

   output logic      resp_valid,
   output reg_data_t resp_rdata,
   input  logic      resp_ready,

   output oq_mask_t  src_oq_empty,
   output oq_mask_t  dst_oq_full,
   output oq_mask_t  enable_send_pkt
);

   // Update strobes from the event decoder
   oq_mask_t  upd_store;
   oq_mask_t  upd_remove;
   oq_mask_t  upd_drop;
   word_cnt_t upd_words;

   // Configuration writes from the host block
   oq_mask_t  cfg_wr;
   oq_reg_e   cfg_idx;
   reg_data_t cfg_data;

   // Per-queue state collected for readback
   pkt_cnt_t  num_pkts_in_q  [`OQ_NUM_QUEUES];
   pkt_cnt_t  max_pkts       [`OQ_NUM_QUEUES];
   word_cnt_t num_words_left [`OQ_NUM_QUEUES];
   word_cnt_t full_thresh    [`OQ_NUM_QUEUES];
   stat_cnt_t num_stored     [`OQ_NUM_QUEUES];
   stat_cnt_t num_removed    [`OQ_NUM_QUEUES];
   stat_cnt_t num_dropped    [`OQ_NUM_QUEUES];

   // ------------------------------------------------------------------------
   // Event decoder
   // ------------------------------------------------------------------------

   oq_event_decode i_event_decode (
      .clk          (clk),
      .arst_n       (arst_n),
      .store_valid  (store_valid),
      .store_oq     (store_oq),
      .store_words  (store_words),
      .store_ready  (store_ready),
      .remove_valid (remove_valid),
      .remove_oq    (remove_oq),
      .remove_words (remove_words),
      .remove_ready (remove_ready),
      .full         (dst_oq_full),
      .enable       (enable_send_pkt),
      .upd_store    (upd_store),
      .upd_remove   (upd_remove),
      .upd_drop     (upd_drop),
      .upd_words    (upd_words)
   );

   // ------------------------------------------------------------------------
   // One state block per queue
   // ------------------------------------------------------------------------

   for (genvar i = 0; i < `OQ_NUM_QUEUES; i++) begin : g_queue
      oq_queue_state i_queue_state (
         .clk            (clk),
         .arst_n         (arst_n),
         .upd_store      (upd_store[i]),
         .upd_remove     (upd_remove[i]),
         .upd_drop       (upd_drop[i]),
         .upd_words      (upd_words),
         .cfg_wr         (cfg_wr[i]),
         .cfg_idx        (cfg_idx),
         .cfg_data       (cfg_data),
         .num_pkts_in_q  (num_pkts_in_q[i]),
         .max_pkts       (max_pkts[i]),
         .num_words_left (num_words_left[i]),
         .full_thresh    (full_thresh[i]),
         .num_stored     (num_stored[i]),
         .num_removed    (num_removed[i]),
         .num_dropped    (num_dropped[i]),
         .empty          (src_oq_empty[i]),
         .full           (dst_oq_full[i]),
         .enable         (enable_send_pkt[i])
      );
   end

   // ------------------------------------------------------------------------
   // Host register port
   // ------------------------------------------------------------------------

   oq_host_regs i_host_regs (
      .clk            (clk),
      .arst_n         (arst_n),
      .req_valid      (req_valid),
      .req_write      (req_write),
      .req_addr       (req_addr),
      .req_wdata      (req_wdata),
      .req_ready      (req_ready),
      .resp_valid     (resp_valid),
      .resp_rdata     (resp_rdata),
      .resp_ready     (resp_ready),
      .cfg_wr         (cfg_wr),
      .cfg_idx        (cfg_idx),
      .cfg_data       (cfg_data),
      .num_pkts_in_q  (num_pkts_in_q),
      .max_pkts       (max_pkts),
      .num_words_left (num_words_left),
      .full_thresh    (full_thresh),
      .num_stored     (num_stored),
      .num_removed    (num_removed),
      .num_dropped    (num_dropped),
      .enable         (enable_send_pkt)
   );

endmodule

// File: dv/tb_oq_regs.sv
/*
 * Directed testbench for the output-queue register block.
 * Inputs change on the falling clock edge and outputs are sampled there.
 * A per-queue reference model gives the expected register values.
 */

`timescale 1ns/10ps

`include "oq_regs_cfg.svh"

module tb_oq_regs
   import oq_regs_pkg::*;
();

   localparam int TIMEOUT = 100;

   logic      clk;
   logic      arst_n;
   logic      store_valid;
   oq_idx_t   store_oq;
   word_cnt_t store_words;
   logic      store_ready;
   logic      remove_valid;
   oq_idx_t   remove_oq;
   word_cnt_t remove_words;
   logic      remove_ready;
   logic      req_valid;
   logic      req_write;
   reg_addr_t req_addr;
   reg_data_t req_wdata;
   logic      req_ready;
   logic      resp_valid;
   reg_data_t resp_rdata;
   logic      resp_ready;
   oq_mask_t  src_oq_empty;
   oq_mask_t  dst_oq_full;
   oq_mask_t  enable_send_pkt;

   int          errors;
   string       test_name;
   logic [31:0] rng_state;
   int unsigned q2_len;

   // Reference model, one entry per queue
   int unsigned m_pkts    [`OQ_NUM_QUEUES];
   int unsigned m_words   [`OQ_NUM_QUEUES];
   int unsigned m_stored  [`OQ_NUM_QUEUES];
   int unsigned m_removed [`OQ_NUM_QUEUES];
   int unsigned m_dropped [`OQ_NUM_QUEUES];
   int unsigned m_en      [`OQ_NUM_QUEUES];
   int unsigned m_max     [`OQ_NUM_QUEUES];
   int unsigned m_thresh  [`OQ_NUM_QUEUES];

   oq_regs i_dut (
      .clk             (clk),
      .arst_n          (arst_n),
      .store_valid     (store_valid),
      .store_oq        (store_oq),
      .store_words     (store_words),
      .store_ready     (store_ready),
      .remove_valid    (remove_valid),
      .remove_oq       (remove_oq),
      .remove_words    (remove_words),
      .remove_ready    (remove_ready),
      .req_valid       (req_valid),
      .req_write       (req_write),
      .req_addr        (req_addr),
      .req_wdata       (req_wdata),
      .req_ready       (req_ready),
      .resp_valid      (resp_valid),
      .resp_rdata      (resp_rdata),
      .resp_ready      (resp_ready),
      .src_oq_empty    (src_oq_empty),
      .dst_oq_full     (dst_oq_full),
      .enable_send_pkt (enable_send_pkt)
   );

   always #4 clk = ~clk;

   // ------------------------------------------------------------------------
   // Random numbers, reference model and checks
   // ------------------------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Packet length in words, 1 to 64
   function automatic word_cnt_t random_words();
      rng_state = xorshift32(rng_state);
      return word_cnt_t'(rng_state % 64 + 1);
   endfunction

   function automatic bit model_full(input int q);
      return (m_pkts[q] >= m_max[q]) || (m_words[q] < m_thresh[q]);
   endfunction

   function automatic reg_data_t expected_reg(input int q, input oq_reg_e idx);
      case (idx)
         REG_CTRL:             return m_en[q];
         REG_MAX_PKTS:         return m_max[q];
         REG_FULL_THRESH:      return m_thresh[q];
         REG_NUM_PKTS_IN_Q:    return m_pkts[q];
         REG_NUM_WORDS_LEFT:   return m_words[q];
         REG_NUM_PKTS_STORED:  return m_stored[q];
         REG_NUM_PKTS_REMOVED: return m_removed[q];
         default:              return m_dropped[q];
      endcase
   endfunction

   function automatic reg_addr_t make_addr(input int q, input oq_reg_e idx);
      reg_addr_t a;
      a.oq  = oq_idx_t'(q);
      a.idx = idx;
      return a;
   endfunction

   task automatic clear_queue_model(input int q);
      m_pkts[q]    = 0;
      m_words[q]   = `OQ_QUEUE_WORDS;
      m_stored[q]  = 0;
      m_removed[q] = 0;
      m_dropped[q] = 0;
   endtask

   task automatic apply_config(input int q, input oq_reg_e idx, input reg_data_t data);
      case (idx)
         REG_CTRL: begin
            m_en[q] = data[0];
            if (data[1]) clear_queue_model(q);
         end
         REG_MAX_PKTS:    m_max[q]    = data[`OQ_PKT_CNT_WIDTH-1:0];
         REG_FULL_THRESH: m_thresh[q] = data[`OQ_WORD_CNT_WIDTH-1:0];
         default:         ;
      endcase
   endtask

   task automatic compare_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
      assert (actual === expected)
         else begin
            errors++;
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
         end
   endtask

   task abort_run(input string why);
      errors++;
      $display("Timeout: %s", why);
      $display("Errors: %0d", errors);
      $display("Regression failed");
      $finish;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // ------------------------------------------------------------------------
   // Host and event drivers, each called and left on a falling edge
   // ------------------------------------------------------------------------

   task automatic host_access(input logic write, input reg_addr_t addr,
                              input reg_data_t wdata, output reg_data_t rdata);
      int cycles;
      req_valid  = 1'b1;
      req_write  = write;
      req_addr   = addr;
      req_wdata  = wdata;
      resp_ready = 1'b1;
      cycles = 0;
      while (!req_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("host request never accepted");
      end
      @(negedge clk);
      req_valid = 1'b0;
      cycles = 0;
      while (!resp_valid) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("host response never arrived");
      end
      rdata = resp_rdata;
      @(negedge clk);
   endtask

   task automatic host_write(input int q, input oq_reg_e idx, input reg_data_t data);
      reg_data_t rdata;
      host_access(1'b1, make_addr(q, idx), data, rdata);
      compare_value("write response data", 0, rdata);
      apply_config(q, idx, data);
   endtask

   task automatic host_read(input int q, input oq_reg_e idx, output reg_data_t data);
      host_access(1'b0, make_addr(q, idx), '0, data);
   endtask

   task automatic send_store(input int q, input word_cnt_t words);
      int cycles;
      store_valid = 1'b1;
      store_oq    = oq_idx_t'(q);
      store_words = words;
      cycles = 0;
      while (!store_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("store event never accepted");
      end
      @(negedge clk);
      store_valid = 1'b0;
      // Full or disabled queue turns the store into a drop
      if (m_en[q] != 0 && !model_full(q)) begin
         m_pkts[q]++;
         m_words[q] -= words;
         m_stored[q]++;
      end else begin
         m_dropped[q]++;
      end
      idle_cycles(3);
   endtask

   task automatic send_remove(input int q, input word_cnt_t words);
      int cycles;
      remove_valid = 1'b1;
      remove_oq    = oq_idx_t'(q);
      remove_words = words;
      cycles = 0;
      while (!remove_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("remove event never accepted");
      end
      @(negedge clk);
      remove_valid = 1'b0;
      m_pkts[q]--;
      m_words[q] += words;
      m_removed[q]++;
      idle_cycles(3);
   endtask

   task automatic audit_queue(input int q);
      reg_data_t v;
      for (int r = 0; r < 8; r++) begin
         host_read(q, oq_reg_e'(r), v);
         compare_value($sformatf("q%0d reg %0d", q, r), expected_reg(q, oq_reg_e'(r)), v);
      end
   endtask

   task automatic check_flags();
      oq_mask_t exp_empty;
      oq_mask_t exp_full;
      oq_mask_t exp_en;
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         exp_empty[q] = (m_pkts[q] == 0);
         exp_full[q]  = model_full(q);
         exp_en[q]    = (m_en[q] != 0);
      end
      compare_value("src_oq_empty", exp_empty, src_oq_empty);
      compare_value("dst_oq_full", exp_full, dst_oq_full);
      compare_value("enable_send_pkt", exp_en, enable_send_pkt);
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------

   task automatic reset_values();
      test_name = "reset_values";
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) audit_queue(q);
      check_flags();
   endtask

   task automatic store_and_remove();
      word_cnt_t len0 [3];
      word_cnt_t len2 [2];
      test_name = "store_and_remove";
      host_write(0, REG_CTRL, 1);
      host_write(2, REG_CTRL, 1);
      for (int i = 0; i < 3; i++) begin
         len0[i] = random_words();
         send_store(0, len0[i]);
      end
      for (int i = 0; i < 2; i++) begin
         len2[i] = random_words();
         send_store(2, len2[i]);
      end
      audit_queue(0);
      audit_queue(2);
      check_flags();
      for (int i = 0; i < 3; i++) send_remove(0, len0[i]);
      send_remove(2, len2[0]);
      q2_len = len2[1];
      audit_queue(0);
      audit_queue(2);
      check_flags();
   endtask

   task automatic drop_when_disabled_or_full();
      test_name = "drop_when_disabled_or_full";
      send_store(1, random_words());
      audit_queue(1);
      host_write(0, REG_MAX_PKTS, 2);
      send_store(0, random_words());
      send_store(0, random_words());
      compare_value("dst_oq_full[0] at limit", 1, dst_oq_full[0]);
      send_store(0, random_words());
      audit_queue(0);
      // Words left dropping under the threshold
      host_write(3, REG_CTRL, 1);
      host_write(3, REG_FULL_THRESH, 2000);
      compare_value("dst_oq_full[3] before store", 0, dst_oq_full[3]);
      send_store(3, 60);
      compare_value("dst_oq_full[3] below threshold", 1, dst_oq_full[3]);
      audit_queue(3);
      check_flags();
   endtask

   task automatic initialize_queue();
      test_name = "initialize";
      host_write(0, REG_CTRL, 3);
      audit_queue(0);
      check_flags();
   endtask

   task automatic arbitration();
      word_cnt_t w;
      int        cycles;
      test_name = "arbitration";
      w = random_words();
      store_valid  = 1'b1;
      store_oq     = 0;
      store_words  = w;
      remove_valid = 1'b1;
      remove_oq    = 2;
      remove_words = word_cnt_t'(q2_len);
      #1;
      compare_value("store_ready while remove valid", 0, store_ready);
      cycles = 0;
      while (!remove_ready) begin
         @(negedge clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT) abort_run("remove event never accepted");
      end
      @(negedge clk);
      remove_valid = 1'b0;
      #1;
      cycles = 0;
      while (!store_ready) begin
         @(negedge clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT) abort_run("store event never accepted after remove");
      end
      @(negedge clk);
      store_valid = 1'b0;
      m_pkts[2]--;
      m_words[2] += q2_len;
      m_removed[2]++;
      m_pkts[0]++;
      m_words[0] -= w;
      m_stored[0]++;
      idle_cycles(3);
      audit_queue(0);
      audit_queue(2);
      check_flags();
   endtask

   task automatic response_backpressure();
      reg_data_t held;
      int        cycles;
      test_name  = "response_backpressure";
      resp_ready = 1'b0;
      req_valid  = 1'b1;
      req_write  = 1'b0;
      req_addr   = make_addr(0, REG_NUM_WORDS_LEFT);
      req_wdata  = '0;
      cycles = 0;
      while (!req_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("host request never accepted");
      end
      @(negedge clk);
      req_valid = 1'b0;
      cycles = 0;
      while (!resp_valid) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("host response never arrived");
      end
      held = resp_rdata;
      compare_value("read data", expected_reg(0, REG_NUM_WORDS_LEFT), held);
      repeat (5) begin
         @(negedge clk);
         compare_value("resp_valid while stalled", 1, resp_valid);
         compare_value("resp_rdata while stalled", held, resp_rdata);
         compare_value("req_ready while stalled", 0, req_ready);
      end
      resp_ready = 1'b1;
      @(negedge clk);
      compare_value("resp_valid after take", 0, resp_valid);
      compare_value("req_ready after take", 1, req_ready);
   endtask

   initial begin
      clk          = 1'b0;
      arst_n       = 1'b0;
      store_valid  = 1'b0;
      store_oq     = '0;
      store_words  = '0;
      remove_valid = 1'b0;
      remove_oq    = '0;
      remove_words = '0;
      req_valid    = 1'b0;
      req_write    = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      resp_ready   = 1'b1;
      errors       = 0;
      q2_len       = 0;
      rng_state    = 32'h2c79;
      for (int q = 0; q < `OQ_NUM_QUEUES; q++) begin
         clear_queue_model(q);
         m_en[q]     = 0;
         m_max[q]    = `OQ_MAX_PKTS_RESET;
         m_thresh[q] = `OQ_FULL_THRESH_RESET;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      reset_values();
      store_and_remove();
      drop_when_disabled_or_full();
      initialize_queue();
      arbitration();
      response_backpressure();

      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: oq_regs.f
+incdir+design
design/oq_regs_pkg.sv
design/oq_event_decode.sv
design/oq_queue_state.sv
design/oq_host_regs.sv
design/oq_regs.sv
dv/tb_oq_regs.sv
